//--- hw/payload_fifo.sv
`timescale 1ns/1ns

module payload_fifo #(
    parameter int FIFO_DEPTH = 256
) (
    input  logic                    clk,
    input  logic                    rst,

    input  udp_cmd_pkg::axis_byte_t fifo_in,
    input  logic                    fifo_in_valid,
    output logic                    fifo_in_ready,

    output udp_cmd_pkg::axis_byte_t tx_pl,
    output logic                    tx_pl_valid,
    input  logic                    tx_pl_ready
);
    import udp_cmd_pkg::*;

    // Depth must be a power of two
    localparam int AW = $clog2(FIFO_DEPTH);

    axis_byte_t  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;

    // Extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign fifo_in_ready = !full;
    assign tx_pl_valid   = !empty;
    assign tx_pl         = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fifo_in_valid && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (tx_pl_ready && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_in_valid && !full) begin
            mem[wr_ptr[AW-1:0]] <= fifo_in;
        end
    end

endmodule

//--- hw/spi_flash_reader.sv
`timescale 1ns/1ns

module spi_flash_reader #(
    parameter int SPI_HALF_PERIOD = 2
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     flash_start,
    input  udp_cmd_pkg::flash_addr_t flash_addr,

    output udp_cmd_pkg::axis_byte_t  flash_data,
    output logic                     flash_valid,
    input  logic                     flash_ready,

    output logic                     spi_sck,
    output logic                     spi_mosi,
    input  logic                     spi_miso,
    output logic                     spi_cs
);
    import udp_cmd_pkg::*;

    localparam int DIV_W = $clog2(SPI_HALF_PERIOD + 1);

    typedef enum logic [1:0] {
        R_IDLE,
        R_CMD,
        R_DATA,
        R_HOLD
    } reader_state_e;

    reader_state_e    state;
    logic [DIV_W-1:0] div_cnt;
    logic [31:0]      shift_out;
    logic [7:0]       shift_in;
    logic [4:0]       bit_cnt;
    logic [7:0]       byte_cnt;
    logic             half_tick;
    logic             byte_done;

    assign half_tick = (div_cnt == DIV_W'(SPI_HALF_PERIOD - 1));
    // Falling edge that ends the eighth data bit
    assign byte_done = (state == R_DATA) && half_tick && spi_sck && (bit_cnt == 5'd7);
    assign spi_mosi  = shift_out[31];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= R_IDLE;
            spi_cs      <= 1'b1;
            spi_sck     <= 1'b0;
            flash_valid <= 1'b0;
            div_cnt     <= '0;
            bit_cnt     <= 5'd0;
            byte_cnt    <= 8'd0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (flash_start) begin
                        spi_cs   <= 1'b0;
                        div_cnt  <= '0;
                        bit_cnt  <= 5'd0;
                        byte_cnt <= 8'd0;
                        state    <= R_CMD;
                    end
                end
                R_CMD, R_DATA: begin
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                    if (half_tick) begin
                        spi_sck <= !spi_sck;
                        if (spi_sck) begin
                            bit_cnt <= bit_cnt + 5'd1;
                            if (state == R_CMD && bit_cnt == 5'd31) begin
                                state <= R_DATA;
                            end
                            if (byte_done) begin
                                bit_cnt     <= 5'd0;
                                byte_cnt    <= byte_cnt + 8'd1;
                                flash_valid <= 1'b1;
                                state       <= R_HOLD;
                                if (byte_cnt == 8'(READ_BYTES - 1)) begin
                                    spi_cs <= 1'b1;
                                end
                            end
                        end
                    end
                end
                R_HOLD: begin
                    // sck stays low here, cs stays low unless the read is over
                    if (flash_ready) begin
                        flash_valid <= 1'b0;
                        state       <= spi_cs ? R_IDLE : R_DATA;
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && flash_start) begin
            shift_out <= {READ, flash_addr};
        end else if (state == R_CMD && half_tick && spi_sck) begin
            shift_out <= {shift_out[30:0], 1'b0};
        end
        // Mode 0, sample on the rising edge
        if (state == R_DATA && half_tick && !spi_sck) begin
            shift_in <= {shift_in[6:0], spi_miso};
        end
        if (byte_done) begin
            flash_data.data <= shift_in;
            flash_data.last <= (byte_cnt == 8'(READ_BYTES - 1));
        end
    end

endmodule

//--- hw/udp_cmd_dispatch.sv
`timescale 1ns/1ns

module udp_cmd_dispatch #(
    parameter logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd2, 8'd128}
) (
    input  logic                     clk,
    input  logic                     rst,

    input  udp_cmd_pkg::udp_hdr_t    rx_hdr,
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_cmd_pkg::axis_byte_t  rx_pl,
    input  logic                     rx_pl_valid,
    output logic                     rx_pl_ready,

    output udp_cmd_pkg::udp_hdr_t    tx_hdr,
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,

    output udp_cmd_pkg::axis_byte_t  fifo_in,
    output logic                     fifo_in_valid,
    input  logic                     fifo_in_ready,

    output logic                     flash_start,
    output udp_cmd_pkg::flash_addr_t flash_addr,
    input  udp_cmd_pkg::axis_byte_t  flash_data,
    input  logic                     flash_valid,
    output logic                     flash_ready
);
    import udp_cmd_pkg::*;

    dispatch_state_e state;
    logic [1:0]      addr_cnt;
    logic            hdr_fire;
    logic            rx_pl_fire;
    logic            fifo_fire;

    assign hdr_fire   = rx_hdr_valid && rx_hdr_ready;
    assign rx_pl_fire = rx_pl_valid && rx_pl_ready;
    assign fifo_fire  = fifo_in_valid && fifo_in_ready;

    assign rx_hdr_ready = (state == ST_IDLE);
    assign tx_hdr_valid = (state == ST_SEND);

    // Payload steering into the reply FIFO
    always_comb begin
        rx_pl_ready   = 1'b0;
        fifo_in_valid = 1'b0;
        flash_ready   = 1'b0;
        fifo_in       = rx_pl;
        case (state)
            ST_ECHO: begin
                rx_pl_ready   = fifo_in_ready;
                fifo_in_valid = rx_pl_valid;
            end
            ST_ADDR, ST_DROP: begin
                rx_pl_ready = 1'b1;
            end
            ST_FLASH: begin
                fifo_in       = flash_data;
                fifo_in_valid = flash_valid;
                flash_ready   = fifo_in_ready;
            end
            default: begin
                rx_pl_ready = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            addr_cnt    <= 2'd0;
            flash_start <= 1'b0;
        end else begin
            flash_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        addr_cnt <= 2'd0;
                        case (rx_hdr.dst_port)
                            PORT_ECHO:     state <= ST_ECHO;
                            PORT_FLASH_RD: state <= ST_ADDR;
                            default:       state <= ST_DROP;
                        endcase
                    end
                end
                ST_ECHO: begin
                    // Whole payload is in the FIFO once last goes in
                    if (fifo_fire && rx_pl.last) begin
                        state <= ST_SEND;
                    end
                end
                ST_ADDR: begin
                    if (rx_pl_fire) begin
                        if (addr_cnt != 2'd3) begin
                            addr_cnt <= addr_cnt + 2'd1;
                        end
                        if (rx_pl.last) begin
                            flash_start <= 1'b1;
                            state       <= ST_FLASH;
                        end
                    end
                end
                ST_FLASH: begin
                    if (fifo_fire && flash_data.last) begin
                        state <= ST_SEND;
                    end
                end
                ST_DROP: begin
                    if (rx_pl_fire && rx_pl.last) begin
                        state <= ST_IDLE;
                    end
                end
                ST_SEND: begin
                    if (tx_hdr_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Reply header and flash address
    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            tx_hdr.src_ip <= LOCAL_IP;
            tx_hdr.dst_ip <= rx_hdr.src_ip;
            if (rx_hdr.dst_port == PORT_FLASH_RD) begin
                tx_hdr.src_port <= PORT_FLASH_RD;
                tx_hdr.dst_port <= PORT_FLASH_REPLY;
                tx_hdr.length   <= 16'(READ_BYTES + UDP_HDR_BYTES);
            end else begin
                tx_hdr.src_port <= PORT_ECHO;
                tx_hdr.dst_port <= rx_hdr.src_port;
                tx_hdr.length   <= rx_hdr.length;
            end
        end
        // Lowest byte arrives first and ends up at the bottom
        if (state == ST_ADDR && rx_pl_fire && addr_cnt != 2'd3) begin
            flash_addr <= {rx_pl.data, flash_addr[23:8]};
        end
    end

endmodule

//--- hw/udp_cmd_pkg.sv
package udp_cmd_pkg;

    // UDP header as seen by the command layer, both directions
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    // One payload byte, valid/ready travel beside it
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } axis_byte_t;

    typedef logic [23:0] flash_addr_t;

    // Port numbers
    localparam logic [15:0] PORT_ECHO        = 16'd1234;
    localparam logic [15:0] PORT_FLASH_RD    = 16'hEEE0;
    localparam logic [15:0] PORT_FLASH_REPLY = 16'hEEE1;

    localparam int READ_BYTES    = 128;
    localparam int UDP_HDR_BYTES = 8;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ECHO,
        ST_ADDR,
        ST_FLASH,
        ST_DROP,
        ST_SEND
    } dispatch_state_e;

    typedef enum logic [7:0] {
        READ = 8'h03
    } spi_opcode_e;

endpackage

//--- hw/udp_cmd_top.sv
`timescale 1ns/1ns

module udp_cmd_top #(
    parameter logic [31:0] LOCAL_IP        = {8'd192, 8'd168, 8'd2, 8'd128},
    parameter int          FIFO_DEPTH      = 256,
    parameter int          SPI_HALF_PERIOD = 2
) (
    input  logic                    clk,
    input  logic                    rst,

    input  udp_cmd_pkg::udp_hdr_t   rx_hdr,
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_cmd_pkg::axis_byte_t rx_pl,
    input  logic                    rx_pl_valid,
    output logic                    rx_pl_ready,

    output udp_cmd_pkg::udp_hdr_t   tx_hdr,
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_cmd_pkg::axis_byte_t tx_pl,
    output logic                    tx_pl_valid,
    input  logic                    tx_pl_ready,

    output logic                    spi_sck,
    output logic                    spi_mosi,
    input  logic                    spi_miso,
    output logic                    spi_cs
);
    import udp_cmd_pkg::*;

    axis_byte_t  fifo_in;
    logic        fifo_in_valid;
    logic        fifo_in_ready;

    logic        flash_start;
    flash_addr_t flash_addr;
    axis_byte_t  flash_data;
    logic        flash_valid;
    logic        flash_ready;

    udp_cmd_dispatch #(
        .LOCAL_IP (LOCAL_IP)
    ) dispatch (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr        (rx_hdr),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_pl         (rx_pl),
        .rx_pl_valid   (rx_pl_valid),
        .rx_pl_ready   (rx_pl_ready),
        .tx_hdr        (tx_hdr),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .fifo_in       (fifo_in),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready),
        .flash_start   (flash_start),
        .flash_addr    (flash_addr),
        .flash_data    (flash_data),
        .flash_valid   (flash_valid),
        .flash_ready   (flash_ready)
    );

    spi_flash_reader #(
        .SPI_HALF_PERIOD (SPI_HALF_PERIOD)
    ) flash_reader (
        .clk         (clk),
        .rst         (rst),
        .flash_start (flash_start),
        .flash_addr  (flash_addr),
        .flash_data  (flash_data),
        .flash_valid (flash_valid),
        .flash_ready (flash_ready),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .spi_cs      (spi_cs)
    );

    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) reply_fifo (
        .clk           (clk),
        .rst           (rst),
        .fifo_in       (fifo_in),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready),
        .tx_pl         (tx_pl),
        .tx_pl_valid   (tx_pl_valid),
        .tx_pl_ready   (tx_pl_ready)
    );

endmodule

//--- sources.f
hw/udp_cmd_pkg.sv
hw/payload_fifo.sv
hw/spi_flash_reader.sv
hw/udp_cmd_dispatch.sv
hw/udp_cmd_top.sv
tb/spi_flash_model.sv
tb/udp_cmd_checker.sv
tb/udp_cmd_assert.sv
tb/udp_cmd_tb.sv

//--- tb/spi_flash_model.sv
`timescale 1ns/1ns

module spi_flash_model (
    input  logic spi_sck,
    input  logic spi_mosi,
    input  logic spi_cs,
    output logic spi_miso
);
    logic [31:0] cmd;
    logic [23:0] addr;
    logic [7:0]  cur;
    int          bit_cnt;
    int          out_bit;

    // Content is the XOR of the three address bytes
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0];
    endfunction

    initial begin
        spi_miso = 1'b0;
        bit_cnt  = 0;
        out_bit  = 7;
    end

    always @(negedge spi_cs) begin
        bit_cnt = 0;
    end

    // Opcode and address, sampled on the rising edge
    always @(posedge spi_sck) begin
        if (!spi_cs && bit_cnt < 32) begin
            cmd     = {cmd[30:0], spi_mosi};
            bit_cnt = bit_cnt + 1;
        end
    end

    // Data changes on the falling edge, MSB first
    always @(negedge spi_sck) begin
        if (!spi_cs && bit_cnt >= 32) begin
            if (bit_cnt == 32) begin
                addr    = cmd[23:0];
                out_bit = 7;
                bit_cnt = 33;
            end else if (out_bit == 0) begin
                addr    = addr + 24'd1;
                out_bit = 7;
            end else begin
                out_bit = out_bit - 1;
            end
            cur      = byte_at(addr);
            // Unknown opcode gives garbage
            spi_miso = (cmd[31:24] == 8'h03) ? cur[out_bit] : 1'bx;
        end
    end

endmodule

//--- tb/udp_cmd_assert.sv
`timescale 1ns/1ns

module udp_cmd_assert (
    input  logic                  clk,
    input  logic                  rst,
    input  udp_cmd_pkg::udp_hdr_t tx_hdr,
    input  logic                  tx_hdr_valid,
    input  logic                  tx_hdr_ready,
    input  logic                  spi_sck,
    input  logic                  spi_cs,
    input  logic                  flash_start
);
    int   fail_count = 0;
    logic start_seen;

    always @(posedge clk) begin
        if (rst) begin
            start_seen <= 1'b0;
        end else if (flash_start) begin
            start_seen <= 1'b1;
        end
    end

    // Reply header holds until taken
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else begin
            fail_count++;
            $error("tx_hdr dropped or changed before tx_hdr_ready");
        end

    sck_idle: assert property (@(posedge clk) disable iff (rst) spi_cs |-> !spi_sck)
        else begin
            fail_count++;
            $error("spi_sck high while spi_cs is high");
        end

    // No flash access before the first command
    cs_quiet: assert property (@(posedge clk) disable iff (rst) !start_seen |-> spi_cs)
        else begin
            fail_count++;
            $error("spi_cs low before any flash_start");
        end

endmodule

bind udp_cmd_top udp_cmd_assert checks (
    .clk          (clk),
    .rst          (rst),
    .tx_hdr       (tx_hdr),
    .tx_hdr_valid (tx_hdr_valid),
    .tx_hdr_ready (tx_hdr_ready),
    .spi_sck      (spi_sck),
    .spi_cs       (spi_cs),
    .flash_start  (flash_start)
);

//--- tb/udp_cmd_checker.sv
`timescale 1ns/1ns

module udp_cmd_checker #(
    parameter int MAX_TESTS = 33
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rx_hdr_ready,
    input  udp_cmd_pkg::udp_hdr_t   tx_hdr,
    input  logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    input  udp_cmd_pkg::axis_byte_t tx_pl,
    input  logic                    tx_pl_valid,
    input  logic                    tx_pl_ready,
    input  logic                    spi_sck,
    input  logic                    spi_cs,
    output int                      tests_done,
    output int                      error_count
);
    import udp_cmd_pkg::*;

    udp_hdr_t   exp_hdr_q[$];
    int         exp_hdr_id_q[$];
    axis_byte_t exp_byte_q[$];
    int         exp_byte_id_q[$];

    bit    hdr_pending [MAX_TESTS];
    int    bytes_left [MAX_TESTS];
    int    test_errs [MAX_TESTS];
    string desc [MAX_TESTS];

    task automatic expect_reply(input int id, input udp_hdr_t hdr, input int nbytes,
                                input string what);
        exp_hdr_q.push_back(hdr);
        exp_hdr_id_q.push_back(id);
        hdr_pending[id] = 1'b1;
        bytes_left[id]  = nbytes;
        desc[id]        = what;
    endtask

    task automatic expect_byte(input int id, input axis_byte_t b);
        exp_byte_q.push_back(b);
        exp_byte_id_q.push_back(id);
    endtask

    task automatic finish_test(input int id);
        tests_done++;
        if (test_errs[id] == 0) begin
            $display("test %0d %s: pass", id, desc[id]);
        end else begin
            $display("test %0d %s: fail, %0d errors", id, desc[id], test_errs[id]);
        end
    endtask

    task automatic discard_done(input int id, input string what);
        desc[id] = what;
        // No reply header and ready for the next frame
        check_field(id, "tx_hdr_valid", 32'd0, tx_hdr_valid);
        check_field(id, "rx_hdr_ready", 32'd1, rx_hdr_ready);
        finish_test(id);
    endtask

    task automatic check_field(input int id, input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp) begin
            $display("error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
            error_count++;
            test_errs[id]++;
        end
    endtask

    initial begin
        tests_done  = 0;
        error_count = 0;
        @(negedge rst);
        check_field(0, "tx_hdr_valid", 32'd0, tx_hdr_valid);
        check_field(0, "tx_pl_valid", 32'd0, tx_pl_valid);
        check_field(0, "spi_cs", 32'd1, spi_cs);
        check_field(0, "spi_sck", 32'd0, spi_sck);
        check_field(0, "rx_hdr_ready", 32'd1, rx_hdr_ready);
        desc[0] = "reset state";
        finish_test(0);
    end

    always @(posedge clk) begin : monitor
        udp_hdr_t   eh;
        axis_byte_t eb;
        int         hid;
        int         bid;
        hid = -1;
        bid = -1;
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            if (exp_hdr_q.size() == 0) begin
                $display("Reply header at %0t ns with no reply outstanding", $time);
                error_count++;
            end else begin
                eh  = exp_hdr_q.pop_front();
                hid = exp_hdr_id_q.pop_front();
                check_field(hid, "tx_hdr.src_ip", eh.src_ip, tx_hdr.src_ip);
                check_field(hid, "tx_hdr.dst_ip", eh.dst_ip, tx_hdr.dst_ip);
                check_field(hid, "tx_hdr.src_port", eh.src_port, tx_hdr.src_port);
                check_field(hid, "tx_hdr.dst_port", eh.dst_port, tx_hdr.dst_port);
                check_field(hid, "tx_hdr.length", eh.length, tx_hdr.length);
                hdr_pending[hid] = 1'b0;
            end
        end
        if (!rst && tx_pl_valid && tx_pl_ready) begin
            if (exp_byte_q.size() == 0) begin
                $display("Reply payload byte at %0t ns with no reply outstanding", $time);
                error_count++;
            end else begin
                eb  = exp_byte_q.pop_front();
                bid = exp_byte_id_q.pop_front();
                check_field(bid, "tx_pl.data", eb.data, tx_pl.data);
                check_field(bid, "tx_pl.last", eb.last, tx_pl.last);
                bytes_left[bid]--;
            end
        end
        // A reply is done once its header and all its bytes are out
        if (hid >= 0 && bytes_left[hid] == 0) begin
            finish_test(hid);
        end
        if (bid >= 0 && bid != hid && bytes_left[bid] == 0 && !hdr_pending[bid]) begin
            finish_test(bid);
        end
    end

endmodule

//--- tb/udp_cmd_tb.sv
`timescale 1ns/1ns

module udp_cmd_tb;
    import udp_cmd_pkg::*;

    localparam logic [31:0] LOCAL_IP        = {8'd192, 8'd168, 8'd2, 8'd128};
    localparam int          SPI_HALF_PERIOD = 2;
    localparam int          MAX_TESTS       = 33;
    localparam int          MARGIN          = 4000;

    logic       clk;
    logic       rst;
    udp_hdr_t   rx_hdr;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    axis_byte_t rx_pl;
    logic       rx_pl_valid;
    logic       rx_pl_ready;
    udp_hdr_t   tx_hdr;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready;
    axis_byte_t tx_pl;
    logic       tx_pl_valid;
    logic       tx_pl_ready;
    logic       spi_sck;
    logic       spi_mosi;
    logic       spi_miso;
    logic       spi_cs;

    int tests_done;
    int error_count;
    int seed = 49257;
    bit bp_on;
    int cycles;
    int cycle_limit;
    int n_tests;

    logic [31:0] t_src_ip [MAX_TESTS];
    logic [15:0] t_src_port [MAX_TESTS];
    logic [15:0] t_dst_port [MAX_TESTS];
    int          t_len [MAX_TESTS];
    logic [23:0] t_addr [MAX_TESTS];
    int          t_bp [MAX_TESTS];
    logic [15:0] t_exp_src [MAX_TESTS];
    logic [15:0] t_exp_dst [MAX_TESTS];
    int          t_exp_len [MAX_TESTS];
    logic [7:0]  stim_q[$];

    udp_cmd_top #(
        .LOCAL_IP        (LOCAL_IP),
        .FIFO_DEPTH      (256),
        .SPI_HALF_PERIOD (SPI_HALF_PERIOD)
    ) uut (.*);

    spi_flash_model flash (.*);

    udp_cmd_checker #(.MAX_TESTS(MAX_TESTS)) chk (.*);

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0];
    endfunction

    task automatic read_tests();
        int    fd;
        int    id;
        string line;
        n_tests = 0;
        fd = $fopen("tb/udp_cmd_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/udp_cmd_tests.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            id = n_tests + 1;
            if (line[0] != "#" && id < MAX_TESTS) begin
                if ($sscanf(line, "%h %h %h %d %h %d %h %h %d", t_src_ip[id], t_src_port[id],
                            t_dst_port[id], t_len[id], t_addr[id], t_bp[id], t_exp_src[id],
                            t_exp_dst[id], t_exp_len[id]) == 9) begin
                    n_tests = id;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic load_expectations();
        udp_hdr_t   hdr;
        axis_byte_t b;
        logic [7:0] d;
        int         nbytes;
        cycle_limit = MARGIN;
        for (int id = 1; id <= n_tests; id++) begin
            cycle_limit += t_len[id] + READ_BYTES * 16 * SPI_HALF_PERIOD;
            nbytes       = t_exp_len[id] - UDP_HDR_BYTES;
            hdr.src_ip   = LOCAL_IP;
            hdr.dst_ip   = t_src_ip[id];
            hdr.src_port = t_exp_src[id];
            hdr.dst_port = t_exp_dst[id];
            hdr.length   = 16'(t_exp_len[id]);
            if (t_dst_port[id] == PORT_FLASH_RD) begin
                chk.expect_reply(id, hdr, nbytes, $sformatf("flash read at %06h", t_addr[id]));
                for (int i = 0; i < nbytes; i++) begin
                    b.data = flash_byte(t_addr[id] + 24'(i));
                    b.last = (i == nbytes - 1);
                    chk.expect_byte(id, b);
                end
            end else begin
                if (t_exp_len[id] != 0) begin
                    chk.expect_reply(id, hdr, nbytes, $sformatf("echo %0d bytes", t_len[id]));
                end
                for (int i = 0; i < t_len[id]; i++) begin
                    d = $random(seed);
                    stim_q.push_back(d);
                    b.data = d;
                    b.last = (i == t_len[id] - 1);
                    if (t_exp_len[id] != 0) begin
                        chk.expect_byte(id, b);
                    end
                end
            end
        end
    endtask

    task automatic send_header(input udp_hdr_t hdr);
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        while (!rx_hdr_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] d, input logic last);
        rx_pl.data  = d;
        rx_pl.last  = last;
        rx_pl_valid = 1'b1;
        while (!rx_pl_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic drive_test(input int id);
        udp_hdr_t   hdr;
        logic [7:0] d;
        bp_on        <= (t_bp[id] != 0);
        hdr.src_ip   = t_src_ip[id];
        hdr.dst_ip   = LOCAL_IP;
        hdr.src_port = t_src_port[id];
        hdr.dst_port = t_dst_port[id];
        hdr.length   = 16'(t_len[id] + UDP_HDR_BYTES);
        send_header(hdr);
        for (int i = 0; i < t_len[id]; i++) begin
            // Flash address goes out lowest byte first
            if (t_dst_port[id] == PORT_FLASH_RD) begin
                d = t_addr[id][8*i +: 8];
            end else begin
                d = stim_q.pop_front();
            end
            send_byte(d, i == t_len[id] - 1);
        end
        rx_pl_valid = 1'b0;
        if (t_exp_len[id] == 0) begin
            chk.discard_done(id, $sformatf("port %04h discarded", t_dst_port[id]));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Random stalls on the transmit side
    always @(negedge clk) begin
        if (bp_on) begin
            tx_pl_ready  = ($random(seed) & 3) != 0;
            tx_hdr_ready = ($random(seed) & 3) != 0;
        end else begin
            tx_pl_ready  = 1'b1;
            tx_hdr_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d tests finished",
                     cycles, tests_done, n_tests + 1);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        rx_hdr       = '0;
        rx_hdr_valid = 1'b0;
        rx_pl        = '0;
        rx_pl_valid  = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_pl_ready  = 1'b1;
        bp_on        = 1'b0;
        cycles       = 0;
        cycle_limit  = 0;
        read_tests();
        load_expectations();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int id = 1; id <= n_tests; id++) begin
            drive_test(id);
        end
        while (tests_done < n_tests + 1) begin
            @(negedge clk);
        end
        // Catch stray reply traffic
        repeat (50) @(negedge clk);
        $display("%0d of %0d tests finished, %0d errors, %0d assertion failures",
                 tests_done, n_tests + 1, error_count, uut.checks.fail_count);
        if (n_tests > 0 && error_count == 0 && uut.checks.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb/udp_cmd_tests.txt
# src_ip   src_port dst_port pl_len addr   bp  exp_src_port exp_dst_port exp_length
# hex      hex      hex      dec    hex    dec hex          hex          dec, 0 means no reply
c0a80201 c350 04d2 16  000000 0 04d2 c350 24
c0a80202 1f90 eee0 3   000100 0 eee0 eee1 136
c0a8020a 2710 0050 20  000000 0 0000 0000 0
c0a80201 c351 04d2 1   000000 0 04d2 c351 9
c0a80203 d431 eee0 3   12abcd 0 eee0 eee1 136
0a000001 0035 1235 5   000000 0 0000 0000 0
0a000001 0036 04d2 64  000000 0 04d2 0036 72
c0a80201 c352 04d2 200 000000 1 04d2 c352 208
c0a80204 8000 eee0 3   fffff0 1 eee0 eee1 136
c0a80201 c353 04d2 33  000000 1 04d2 c353 41
